//--- hdl/fetch_pkg.sv
package fetch_pkg;

    // datapath
    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h1eceb000;

    // burst memory geometry
    localparam int BEAT_BITS      = 64;
    localparam int BEATS_PER_LINE = 4;
    localparam int LINE_BITS      = BEAT_BITS * BEATS_PER_LINE;  // 256
    localparam int WORDS_PER_LINE = LINE_BITS / XLEN;            // 8

    // byte offset inside a line
    localparam int LINE_OFFSET_BITS = $clog2(LINE_BITS / 8);

    localparam int BEAT_IDX_BITS = $clog2(BEATS_PER_LINE);
    localparam int WORD_IDX_BITS = $clog2(WORDS_PER_LINE);

    // fetch queue sizing
    localparam int QUEUE_DEPTH    = 16;
    localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_BITS = QUEUE_PTR_BITS + 1;  // room for the full count

    // one fetched word and where it came from
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_entry_t;

endpackage

//--- hdl/rv32i_pkg.sv
package rv32i_pkg;

    localparam int REG_ADDR_BITS = 5;

    // base opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // M extension lives under OP_REG with this funct7
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // reservation station select in the dispatch encoding
    typedef enum logic [2:0] {
        FU_ADD = 3'd0,
        FU_MUL = 3'd1,
        FU_DIV = 3'd2,
        FU_MEM = 3'd3,
        FU_BR  = 3'd4
    } fu_class_e;

    typedef struct packed {
        logic [6:0]               funct7;
        logic [REG_ADDR_BITS-1:0] rs2;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [2:0]               funct3;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [6:0]               opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]              imm;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [2:0]               funct3;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [6:0]               opcode;
    } i_type_t;

    // same 32 bits, two field layouts
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_word_u;

    // what dispatch needs to pick a station and look up sources
    typedef struct packed {
        logic [fetch_pkg::XLEN-1:0] pc;
        logic [fetch_pkg::XLEN-1:0] inst;
        fu_class_e                  fu_class;
        logic [REG_ADDR_BITS-1:0]   rd;
        logic [REG_ADDR_BITS-1:0]   rs1;
        logic [REG_ADDR_BITS-1:0]   rs2;
        logic                       uses_rs1;
        logic                       uses_rs2;
        logic                       writes_rd;
    } predecoded_t;

endpackage

//--- hdl/line_fetch.sv
`timescale 1ns/1ps

module line_fetch (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             redirect_i,
    input  logic [fetch_pkg::XLEN-1:0]       redirect_pc_i,
    output logic [fetch_pkg::XLEN-1:0]       bmem_addr_o,
    output logic                             bmem_read_o,
    input  logic                             bmem_ready_i,
    input  logic [fetch_pkg::BEAT_BITS-1:0]  bmem_rdata_i,
    input  logic                             bmem_rvalid_i,
    output fetch_pkg::fetch_entry_t          entry_o,
    output logic                             entry_valid_o,
    input  logic                             entry_ready_i
);

    typedef enum logic [1:0] {
        S_REQ,      // holding the burst read request
        S_WAIT,     // collecting beats of the line
        S_ISSUE,    // handing words to the queue
        S_DISCARD   // draining beats of a dropped line
    } state_e;

    state_e                                                state_q, state_d;
    logic [fetch_pkg::XLEN-1:0]                            pc_q, pc_d;
    logic [fetch_pkg::XLEN-1:fetch_pkg::LINE_OFFSET_BITS]  req_line_q;
    logic [fetch_pkg::BEAT_IDX_BITS-1:0]                   beat_cnt_q;
    logic [fetch_pkg::LINE_BITS-1:0]                       line_q;
    logic [fetch_pkg::WORD_IDX_BITS-1:0]                   word_idx;
    logic                                                  armed_q;  // one idle cycle out of reset
    logic                                                  req_fire;
    logic                                                  last_beat;
    logic                                                  word_taken;

    assign bmem_read_o = (state_q == S_REQ) && armed_q;
    assign bmem_addr_o = {req_line_q, {fetch_pkg::LINE_OFFSET_BITS{1'b0}}};
    assign req_fire    = bmem_read_o && bmem_ready_i;

    assign last_beat = bmem_rvalid_i
        && (beat_cnt_q == fetch_pkg::BEAT_IDX_BITS'(fetch_pkg::BEATS_PER_LINE - 1));

    // word select straight from the pc
    assign word_idx      = pc_q[fetch_pkg::LINE_OFFSET_BITS-1 -: fetch_pkg::WORD_IDX_BITS];
    assign entry_valid_o = (state_q == S_ISSUE);
    assign entry_o.pc    = pc_q;
    assign entry_o.inst  = line_q[word_idx*fetch_pkg::XLEN +: fetch_pkg::XLEN];
    assign word_taken    = entry_valid_o && entry_ready_i;

    always_comb begin
        if (redirect_i) begin
            pc_d = redirect_pc_i;
        end else if (word_taken) begin
            pc_d = pc_q + fetch_pkg::XLEN'(4);
        end else begin
            pc_d = pc_q;
        end

        state_d = state_q;
        case (state_q)
            S_REQ: begin
                if (req_fire) begin
                    // a redirect into the same line can still use it
                    if (pc_d[fetch_pkg::XLEN-1:fetch_pkg::LINE_OFFSET_BITS] == req_line_q) begin
                        state_d = S_WAIT;
                    end else begin
                        state_d = S_DISCARD;
                    end
                end
            end
            S_WAIT: begin
                if (redirect_i) begin
                    state_d = last_beat ? S_REQ : S_DISCARD;
                end else if (last_beat) begin
                    state_d = S_ISSUE;
                end
            end
            S_ISSUE: begin
                if (redirect_i) begin
                    state_d = S_REQ;
                end else if (word_taken
                    && word_idx == fetch_pkg::WORD_IDX_BITS'(fetch_pkg::WORDS_PER_LINE - 1)) begin
                    state_d = S_REQ;  // line used up
                end
            end
            S_DISCARD: begin
                if (last_beat) begin
                    state_d = S_REQ;
                end
            end
            default: state_d = S_REQ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= S_REQ;
            pc_q       <= fetch_pkg::RESET_PC;
            req_line_q <= fetch_pkg::RESET_PC[fetch_pkg::XLEN-1:fetch_pkg::LINE_OFFSET_BITS];
            beat_cnt_q <= '0;
            armed_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
            armed_q <= 1'b1;
            if (state_d == S_REQ && state_q != S_REQ) begin
                req_line_q <= pc_d[fetch_pkg::XLEN-1:fetch_pkg::LINE_OFFSET_BITS];
            end
            if (state_q == S_REQ) begin
                beat_cnt_q <= '0;
            end else if (bmem_rvalid_i) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
        end
    end

    // beats land lowest first
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i && state_q == S_WAIT) begin
            line_q[beat_cnt_q*fetch_pkg::BEAT_BITS +: fetch_pkg::BEAT_BITS] <= bmem_rdata_i;
        end
    end

    // request must not move until memory takes it
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o && !bmem_ready_i |=> bmem_read_o && $stable(bmem_addr_o));

    // memory only answers a request that was taken
    a_no_stray_beat: assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> (state_q == S_WAIT || state_q == S_DISCARD));

endmodule

//--- hdl/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush_i,
    input  fetch_pkg::fetch_entry_t  wr_i,
    input  logic                     wr_valid_i,
    output logic                     wr_ready_o,
    output fetch_pkg::fetch_entry_t  rd_o,
    output logic                     rd_valid_o,
    input  logic                     rd_ready_i
);

    fetch_pkg::fetch_entry_t                mem_q [fetch_pkg::QUEUE_DEPTH];
    logic [fetch_pkg::QUEUE_PTR_BITS-1:0]   wr_ptr_q, rd_ptr_q;
    logic [fetch_pkg::QUEUE_CNT_BITS-1:0]   count_q;
    logic                                   push, pop;

    assign wr_ready_o = count_q != fetch_pkg::QUEUE_CNT_BITS'(fetch_pkg::QUEUE_DEPTH);
    assign rd_valid_o = count_q != '0;
    assign rd_o       = mem_q[rd_ptr_q];

    assign push = wr_valid_i && wr_ready_o;
    assign pop  = rd_valid_o && rd_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // everything queued is on the wrong path
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // pc and inst stay together in one slot
    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= wr_i;
        end
    end

    // a full queue takes nothing at that edge
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        count_q == fetch_pkg::QUEUE_CNT_BITS'(fetch_pkg::QUEUE_DEPTH) && !flush_i
        |=> $stable(wr_ptr_q));

    // count bounded and in step with the pointers
    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count_q <= fetch_pkg::QUEUE_CNT_BITS'(fetch_pkg::QUEUE_DEPTH)
        && (wr_ptr_q - rd_ptr_q) == count_q[fetch_pkg::QUEUE_PTR_BITS-1:0]);

endmodule

//--- hdl/predecode.sv
`timescale 1ns/1ps

module predecode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush_i,
    input  fetch_pkg::fetch_entry_t  in_i,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    output rv32i_pkg::predecoded_t   dec_o,
    output logic                     dec_valid_o,
    input  logic                     dec_ready_i
);

    rv32i_pkg::inst_word_u   iw;
    rv32i_pkg::predecoded_t  dec_d, dec_q;
    logic                    valid_q;
    logic                    accept;

    // empty register or draining this cycle
    assign in_ready_o  = !valid_q || dec_ready_i;
    assign accept      = in_valid_i && in_ready_o && !flush_i;
    assign dec_o       = dec_q;
    assign dec_valid_o = valid_q;

    always_comb begin
        iw    = in_i.inst;
        dec_d = '0;

        dec_d.pc   = in_i.pc;
        dec_d.inst = in_i.inst;
        dec_d.rd   = iw.i.rd;
        dec_d.rs1  = iw.i.rs1;
        dec_d.rs2  = iw.r.rs2;  // raw field that only matters with uses_rs2

        case (iw.i.opcode)
            rv32i_pkg::OP_JAL, rv32i_pkg::OP_JALR, rv32i_pkg::OP_BRANCH: begin
                dec_d.fu_class = rv32i_pkg::FU_BR;
            end
            rv32i_pkg::OP_LOAD, rv32i_pkg::OP_STORE: begin
                dec_d.fu_class = rv32i_pkg::FU_MEM;
            end
            rv32i_pkg::OP_REG: begin
                if (iw.r.funct7 == rv32i_pkg::FUNCT7_MULDIV) begin
                    // funct3 4..7 are div/rem
                    dec_d.fu_class = iw.r.funct3[2] ? rv32i_pkg::FU_DIV : rv32i_pkg::FU_MUL;
                end else begin
                    dec_d.fu_class = rv32i_pkg::FU_ADD;
                end
            end
            default: dec_d.fu_class = rv32i_pkg::FU_ADD;  // lui, auipc, op-imm
        endcase

        dec_d.uses_rs1 = !(iw.i.opcode inside {rv32i_pkg::OP_LUI, rv32i_pkg::OP_AUIPC,
                                               rv32i_pkg::OP_JAL});
        dec_d.uses_rs2 = iw.i.opcode inside {rv32i_pkg::OP_REG, rv32i_pkg::OP_BRANCH,
                                             rv32i_pkg::OP_STORE};
        dec_d.writes_rd = (iw.i.rd != '0)
            && !(iw.i.opcode inside {rv32i_pkg::OP_BRANCH, rv32i_pkg::OP_STORE});
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (dec_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_q <= dec_d;
        end
    end

    // output held steady until dispatch takes it
    a_dec_hold: assert property (@(posedge clk) disable iff (rst)
        dec_valid_o && !dec_ready_i && !flush_i |=> dec_valid_o && $stable(dec_o));

endmodule

//--- hdl/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend (
    input  logic                             clk,
    input  logic                             rst,

    // read side of burst memory
    output logic [fetch_pkg::XLEN-1:0]       bmem_addr_o,
    output logic                             bmem_read_o,
    input  logic                             bmem_ready_i,
    input  logic [fetch_pkg::BEAT_BITS-1:0]  bmem_rdata_i,
    input  logic                             bmem_rvalid_i,

    // branch resolution from the back end
    input  logic                             redirect_valid_i,
    input  logic [fetch_pkg::XLEN-1:0]       redirect_pc_i,

    // to dispatch
    output rv32i_pkg::predecoded_t           dec_o,
    output logic                             dec_valid_o,
    input  logic                             dec_ready_i
);

    fetch_pkg::fetch_entry_t  lf_entry, fq_entry;
    logic                     lf_valid, lf_ready;
    logic                     fq_valid, fq_ready;

    line_fetch u_line_fetch (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_valid_i),
        .redirect_pc_i (redirect_pc_i),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .entry_o       (lf_entry),
        .entry_valid_o (lf_valid),
        .entry_ready_i (lf_ready)
    );

    fetch_queue u_fetch_queue (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (redirect_valid_i),
        .wr_i       (lf_entry),
        .wr_valid_i (lf_valid),
        .wr_ready_o (lf_ready),
        .rd_o       (fq_entry),
        .rd_valid_o (fq_valid),
        .rd_ready_i (fq_ready)
    );

    predecode u_predecode (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (redirect_valid_i),
        .in_i        (fq_entry),
        .in_valid_i  (fq_valid),
        .in_ready_o  (fq_ready),
        .dec_o       (dec_o),
        .dec_valid_o (dec_valid_o),
        .dec_ready_i (dec_ready_i)
    );

endmodule

//--- tb/tb_fetch_frontend.sv
`timescale 1ns/1ps

module tb_fetch_frontend;

    logic                    clk;
    logic                    rst;
    logic [31:0]             bmem_addr_o;
    logic                    bmem_read_o;
    logic                    bmem_ready_i;
    logic [63:0]             bmem_rdata_i;
    logic                    bmem_rvalid_i;
    logic                    redirect_valid_i;
    logic [31:0]             redirect_pc_i;
    rv32i_pkg::predecoded_t  dec_o;
    logic                    dec_valid_o;
    logic                    dec_ready_i;

    logic [31:0] trace_mem [0:255];
    int          n_img, n_red, n_exp, img_base;
    logic        loaded;
    integer      seed;

    // per-test error counts
    int reset_err, stream_err, hold_err, redir_err, dec_err, proto_err;
    int n_acc, ri;
    logic [31:0] exp_pc;
    logic        after_redirect;
    logic        hold_pending;
    rv32i_pkg::predecoded_t held;
    logic        first_cycle, first_req;

    // memory model state
    logic        in_burst;
    logic [1:0]  delay, gap;
    logic [2:0]  beat;
    logic [31:0] req_addr;

    fetch_frontend DUT (
        .clk              (clk),
        .rst              (rst),
        .bmem_addr_o      (bmem_addr_o),
        .bmem_read_o      (bmem_read_o),
        .bmem_ready_i     (bmem_ready_i),
        .bmem_rdata_i     (bmem_rdata_i),
        .bmem_rvalid_i    (bmem_rvalid_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .dec_o            (dec_o),
        .dec_valid_o      (dec_valid_o),
        .dec_ready_i      (dec_ready_i)
    );

    always #20 clk = ~clk;

    // image word, or an address-derived fill outside the image
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - fetch_pkg::RESET_PC) >> 2;
        if (addr >= fetch_pkg::RESET_PC && idx < 32'(n_img)) begin
            return trace_mem[32'(img_base) + idx];
        end
        return {addr[15:0], addr[31:16]} ^ 32'h6b3c_9a15;
    endfunction

    function automatic logic [2:0] class_of(input logic [31:0] w);
        case (w[6:0])
            7'h6f, 7'h67, 7'h63: return 3'd4;
            7'h03, 7'h23:        return 3'd3;
            7'h33: begin
                if (w[31:25] == 7'd1) begin
                    return (w[14:12] >= 3'd4) ? 3'd2 : 3'd1;
                end
                return 3'd0;
            end
            default: return 3'd0;
        endcase
    endfunction

    function automatic logic reads_rs1(input logic [31:0] w);
        return !(w[6:0] == 7'h37 || w[6:0] == 7'h17 || w[6:0] == 7'h6f);
    endfunction

    function automatic logic reads_rs2(input logic [31:0] w);
        return w[6:0] == 7'h33 || w[6:0] == 7'h63 || w[6:0] == 7'h23;
    endfunction

    function automatic logic has_dest(input logic [31:0] w);
        return w[11:7] != 5'd0 && !(w[6:0] == 7'h63 || w[6:0] == 7'h23);
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
        $display("FAILED t=%0t %s expected=%h got=%h", $time, name, exp_v, got_v);
    endtask

    // both outputs must be quiet in and right after reset
    task automatic check_idle();
        if (dec_valid_o) begin
            show_mismatch("dec_valid_o", 32'd0, {31'd0, dec_valid_o});
            reset_err++;
        end
        if (bmem_read_o) begin
            show_mismatch("bmem_read_o", 32'd0, {31'd0, bmem_read_o});
            reset_err++;
        end
    endtask

    task automatic check_output();
        logic [31:0] w;
        int          errs;
        w    = mem_word(exp_pc);
        errs = 0;
        if (dec_o.pc != exp_pc) begin
            show_mismatch("dec_o.pc", exp_pc, dec_o.pc);
            if (after_redirect) redir_err++;
            else stream_err++;
        end
        if (dec_o.inst != w) begin
            show_mismatch("dec_o.inst", w, dec_o.inst);
            stream_err++;
        end
        if (dec_o.fu_class != class_of(w)) begin
            show_mismatch("dec_o.fu_class", {29'd0, class_of(w)}, {29'd0, dec_o.fu_class});
            errs++;
        end
        if (dec_o.rd != w[11:7]) begin
            show_mismatch("dec_o.rd", {27'd0, w[11:7]}, {27'd0, dec_o.rd});
            errs++;
        end
        if (dec_o.rs1 != w[19:15]) begin
            show_mismatch("dec_o.rs1", {27'd0, w[19:15]}, {27'd0, dec_o.rs1});
            errs++;
        end
        if (dec_o.rs2 != w[24:20]) begin
            show_mismatch("dec_o.rs2", {27'd0, w[24:20]}, {27'd0, dec_o.rs2});
            errs++;
        end
        if (dec_o.uses_rs1 != reads_rs1(w)) begin
            show_mismatch("dec_o.uses_rs1", {31'd0, reads_rs1(w)}, {31'd0, dec_o.uses_rs1});
            errs++;
        end
        if (dec_o.uses_rs2 != reads_rs2(w)) begin
            show_mismatch("dec_o.uses_rs2", {31'd0, reads_rs2(w)}, {31'd0, dec_o.uses_rs2});
            errs++;
        end
        if (dec_o.writes_rd != has_dest(w)) begin
            show_mismatch("dec_o.writes_rd", {31'd0, has_dest(w)}, {31'd0, dec_o.writes_rd});
            errs++;
        end
        dec_err += errs;
        exp_pc = exp_pc + 32'd4;
        after_redirect = 1'b0;
    endtask

    // burst memory model with ready after 0..3 cycles and random beat gaps
    always @(posedge clk) begin
        logic [31:0] r;
        logic [31:0] baddr;
        if (rst) begin
            bmem_ready_i  <= 1'b0;
            bmem_rvalid_i <= 1'b0;
            in_burst      = 1'b0;
            delay         = 2'd0;
        end else if (!in_burst) begin
            bmem_rvalid_i <= 1'b0;
            if (bmem_read_o && bmem_ready_i) begin
                if (bmem_addr_o[4:0] != 5'd0) begin
                    show_mismatch("bmem_addr_o[4:0]", 32'd0, {27'd0, bmem_addr_o[4:0]});
                    proto_err++;
                end
                req_addr     = bmem_addr_o;
                bmem_ready_i <= 1'b0;
                beat         = 3'd0;
                r            = $random(seed);
                gap          = r[1:0];
                in_burst     = 1'b1;
            end else if (bmem_read_o) begin
                if (delay == 2'd0) bmem_ready_i <= 1'b1;
                else delay = delay - 2'd1;
            end
        end else begin
            bmem_rvalid_i <= 1'b0;
            if (bmem_read_o) begin
                $display("protocol error: new request before four beats returned");
                proto_err++;
            end
            if (gap == 2'd0) begin
                baddr = req_addr + {26'd0, beat, 3'b000};
                bmem_rvalid_i <= 1'b1;
                bmem_rdata_i  <= {mem_word(baddr + 32'd4), mem_word(baddr)};
                beat = beat + 3'd1;
                r    = $random(seed);
                gap  = r[1:0];
                if (beat == 3'd4) begin
                    in_burst = 1'b0;
                    r        = $random(seed);
                    delay    = r[3:2];
                end
            end else begin
                gap = gap - 2'd1;
            end
        end
    end

    // output checker, ready and redirect driver
    always @(posedge clk) begin
        logic [31:0] r;
        logic        redirecting;
        redirecting = 1'b0;
        if (rst) begin
            check_idle();
        end else begin
            if (first_cycle) begin
                check_idle();
                first_cycle = 1'b0;
            end
            if (first_req && bmem_read_o) begin
                if (bmem_addr_o != {fetch_pkg::RESET_PC[31:5], 5'd0}) begin
                    show_mismatch("bmem_addr_o", {fetch_pkg::RESET_PC[31:5], 5'd0}, bmem_addr_o);
                    reset_err++;
                end
                first_req = 1'b0;
                $display("test reset: %s", (reset_err == 0) ? "ok" : "errors");
            end
            if (hold_pending && (!dec_valid_o || dec_o != held)) begin
                $display("FAILED t=%0t dec_o expected=%h got=%h", $time, held, dec_o);
                hold_err++;
            end
            hold_pending = dec_valid_o && !dec_ready_i && !redirect_valid_i;
            held         = dec_o;
            if (dec_valid_o && dec_ready_i && n_acc < n_exp) begin
                check_output();
                n_acc++;
                if (ri < n_red && n_acc == int'(trace_mem[3 + 2*ri])) begin
                    redirect_valid_i <= 1'b1;
                    redirect_pc_i    <= trace_mem[4 + 2*ri];
                    dec_ready_i      <= 1'b0;
                    exp_pc         = trace_mem[4 + 2*ri];
                    after_redirect = 1'b1;
                    ri++;
                    redirecting = 1'b1;
                end
            end
            if (!redirecting) begin
                r = $random(seed);
                redirect_valid_i <= 1'b0;
                dec_ready_i      <= (r[1:0] != 2'b00);
            end
        end
    end

    initial begin
        int total_err;
        int failed_tests;
        clk = 1'b0;
        rst = 1'b1;
        bmem_ready_i = 1'b0;
        bmem_rdata_i = '0;
        bmem_rvalid_i = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i = '0;
        dec_ready_i = 1'b0;
        seed = 32'hd568_de4f;
        {reset_err, stream_err, hold_err, redir_err, dec_err, proto_err} = '0;
        n_acc = 0;
        ri = 0;
        exp_pc = fetch_pkg::RESET_PC;
        after_redirect = 1'b0;
        hold_pending = 1'b0;
        first_cycle = 1'b1;
        first_req = 1'b1;
        in_burst = 1'b0;
        loaded = 1'b0;

        $readmemh("tb/fetch_trace.txt", trace_mem);
        n_img    = int'(trace_mem[0]);
        n_red    = int'(trace_mem[1]);
        n_exp    = int'(trace_mem[2]);
        img_base = 3 + 2*n_red;
        loaded   = 1'b1;

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        wait (n_acc == n_exp);
        repeat (4) @(posedge clk);
        if (ri != n_red) begin
            $display("redirect error: only %0d of %0d redirects given", ri, n_red);
            redir_err++;
        end
        $display("test stream: %0d outputs, %0d errors", n_acc, stream_err);
        $display("test back-pressure: %0d errors", hold_err);
        $display("test redirect: %0d redirects, %0d errors", ri, redir_err);
        $display("test predecode: %0d errors", dec_err);
        $display("test memory protocol: %0d errors", proto_err);
        failed_tests = 0;
        if (reset_err != 0) failed_tests++;
        if (stream_err != 0) failed_tests++;
        if (hold_err != 0) failed_tests++;
        if (redir_err != 0) failed_tests++;
        if (dec_err != 0) failed_tests++;
        if (proto_err != 0) failed_tests++;
        total_err = reset_err + stream_err + hold_err + redir_err + dec_err + proto_err;
        $display("summary: 6 tests, %0d passed, %0d failed, %0d errors",
                 6 - failed_tests, failed_tests, total_err);
        if (total_err == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog sized from the expected output count
    initial begin
        wait (loaded);
        repeat (200 * (n_exp + 1)) @(posedge clk);
        $display("timeout: only %0d of %0d outputs accepted", n_acc, n_exp);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- tb/fetch_trace.txt
// header: image word count, redirect count, expected output count
00000018 00000002 0000001e
// redirects: output count after which to redirect, target pc
00000005 1eceb034
0000000c 1eceb008
// image words from the reset pc, eight per line
002081b3 024182b3 0212c333 00812383 00712623 00208863 00500093 12345237
008000ef 00008067 00001417 0221f4b3 02209533 00000013 404185b3 002081b3
00812383 0212c333 00712623 024182b3 00208863 0221f4b3 00500093 008000ef

//--- build.f
hdl/fetch_pkg.sv
hdl/rv32i_pkg.sv
hdl/line_fetch.sv
hdl/fetch_queue.sv
hdl/predecode.sv
hdl/fetch_frontend.sv
tb/tb_fetch_frontend.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f
TRACE     ?= tb/fetch_trace.txt
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) $(TRACE)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then exit 1; fi
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
